// File: rtl/plic_defs.svh
`ifndef PLIC_DEFS_SVH
`define PLIC_DEFS_SVH

// Source 0 is reserved and never pends
`define PLIC_SRC_NUM    16
`define PLIC_TGT_NUM    2
`define PLIC_PRIO_W     3

// Register offsets within paddr[11:0]
`define PLIC_ADDR_W     12
`define PLIC_PRIO_BASE  12'h000
`define PLIC_PEND_ADDR  12'h080
`define PLIC_TYPE_ADDR  12'h084
`define PLIC_POL_ADDR   12'h088

// Per-target enable vectors
`define PLIC_EN_BASE    12'h200
`define PLIC_EN_STRIDE  12'h080

// Per-target threshold, claim/complete sits one word above
`define PLIC_TH_BASE    12'h400
`define PLIC_TH_STRIDE  12'h100
`define PLIC_CLAIM_OFS  12'h004

`endif

// File: rtl/plic_pkg.sv
`default_nettype none
`include "plic_defs.svh"

package plic_pkg;

    typedef logic [$clog2(`PLIC_SRC_NUM)-1:0] src_id_t;
    typedef logic [`PLIC_PRIO_W-1:0]          prio_t;
    typedef logic [`PLIC_SRC_NUM-1:0]         src_vec_t;

    typedef struct packed {
        logic                    sel;
        logic                    enable;
        logic                    write;
        logic [`PLIC_ADDR_W-1:0] addr;
        logic [31:0]             wdata;
    } apb_req_t;

    // Type bit 1 selects level, polarity bit 1 selects active low
    typedef struct packed {
        prio_t    [`PLIC_SRC_NUM-1:0] prio;
        src_vec_t                     src_type;
        src_vec_t                     src_pol;
        src_vec_t [`PLIC_TGT_NUM-1:0] enable;
        prio_t    [`PLIC_TGT_NUM-1:0] threshold;
    } plic_cfg_t;

    typedef struct packed {
        src_id_t id;
        prio_t   prio;
    } tgt_cand_t;

    typedef struct packed {
        logic    valid;
        src_id_t id;
    } gw_evt_t;

    typedef enum logic [1:0] {
        IDLE,
        PEND,
        CLAIM
    } gw_state_e;

endpackage

`default_nettype wire

// File: rtl/plic_regs.sv
`timescale 1ns/100ps
`default_nettype none
`include "plic_defs.svh"

module plic_regs import plic_pkg::*; (
    input  wire                              clk,
    input  wire                              rstn,
    input  wire apb_req_t                    apb_i,
    input  wire src_vec_t                    pend_i,
    input  wire src_id_t [`PLIC_TGT_NUM-1:0] cand_id_i,
    output logic [31:0]                      prdata_o,
    output plic_cfg_t                        cfg_o,
    output logic [`PLIC_TGT_NUM-1:0]         claim_rd_o,
    output logic [`PLIC_TGT_NUM-1:0]         complete_wr_o
);

    plic_cfg_t                cfg_q;
    logic                     wr_en;
    logic                     setup_rd;
    logic                     setup_wr;
    logic [`PLIC_TGT_NUM-1:0] claim_hit;
    logic [31:0]              rdata;

    function automatic logic addr_hit(input logic [`PLIC_ADDR_W-1:0] addr, input int ofs);
        return 32'(addr) == ofs;
    endfunction

    // Writes land in the access phase, claim traffic in the setup phase
    assign wr_en    = apb_i.sel & apb_i.enable & apb_i.write;
    assign setup_rd = apb_i.sel & ~apb_i.enable & ~apb_i.write;
    assign setup_wr = apb_i.sel & ~apb_i.enable & apb_i.write;

    always_comb begin
        for (int t = 0; t < `PLIC_TGT_NUM; t++) begin
            claim_hit[t]     = addr_hit(apb_i.addr,
                                        `PLIC_TH_BASE + `PLIC_TH_STRIDE * t + `PLIC_CLAIM_OFS);
            // Only a candidate that is still pending can be claimed
            claim_rd_o[t]    = setup_rd & claim_hit[t] & pend_i[cand_id_i[t]];
            complete_wr_o[t] = setup_wr & claim_hit[t];
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cfg_q <= '0;
        end
        else if (wr_en) begin
            // No priority register behind source 0
            for (int i = 1; i < `PLIC_SRC_NUM; i++) begin
                if (addr_hit(apb_i.addr, `PLIC_PRIO_BASE + 4 * i)) begin
                    cfg_q.prio[i] <= apb_i.wdata[`PLIC_PRIO_W-1:0];
                end
            end
            if (addr_hit(apb_i.addr, `PLIC_TYPE_ADDR)) begin
                cfg_q.src_type <= apb_i.wdata[`PLIC_SRC_NUM-1:0];
            end
            if (addr_hit(apb_i.addr, `PLIC_POL_ADDR)) begin
                cfg_q.src_pol <= apb_i.wdata[`PLIC_SRC_NUM-1:0];
            end
            for (int t = 0; t < `PLIC_TGT_NUM; t++) begin
                if (addr_hit(apb_i.addr, `PLIC_EN_BASE + `PLIC_EN_STRIDE * t)) begin
                    cfg_q.enable[t] <= apb_i.wdata[`PLIC_SRC_NUM-1:0];
                end
                if (addr_hit(apb_i.addr, `PLIC_TH_BASE + `PLIC_TH_STRIDE * t)) begin
                    cfg_q.threshold[t] <= apb_i.wdata[`PLIC_PRIO_W-1:0];
                end
            end
        end
    end

    always_comb begin
        rdata = '0;
        for (int i = 0; i < `PLIC_SRC_NUM; i++) begin
            if (addr_hit(apb_i.addr, `PLIC_PRIO_BASE + 4 * i)) begin
                rdata = 32'(cfg_q.prio[i]);
            end
        end
        if (addr_hit(apb_i.addr, `PLIC_PEND_ADDR)) begin
            rdata = 32'(pend_i);
        end
        if (addr_hit(apb_i.addr, `PLIC_TYPE_ADDR)) begin
            rdata = 32'(cfg_q.src_type);
        end
        if (addr_hit(apb_i.addr, `PLIC_POL_ADDR)) begin
            rdata = 32'(cfg_q.src_pol);
        end
        for (int t = 0; t < `PLIC_TGT_NUM; t++) begin
            if (addr_hit(apb_i.addr, `PLIC_EN_BASE + `PLIC_EN_STRIDE * t)) begin
                rdata = 32'(cfg_q.enable[t]);
            end
            if (addr_hit(apb_i.addr, `PLIC_TH_BASE + `PLIC_TH_STRIDE * t)) begin
                rdata = 32'(cfg_q.threshold[t]);
            end
            if (claim_rd_o[t]) begin
                rdata = 32'(cand_id_i[t]);
            end
        end
    end

    // Captured at the end of setup so it holds through the access phase
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            prdata_o <= '0;
        end
        else if (setup_rd) begin
            prdata_o <= rdata;
        end
    end

    assign cfg_o = cfg_q;

endmodule

`default_nettype wire

// File: rtl/plic_gateway_bank.sv
`timescale 1ns/100ps
`default_nettype none
`include "plic_defs.svh"

module plic_gateway_bank import plic_pkg::*; (
    input  wire                              clk,
    input  wire                              rstn,
    input  wire src_vec_t                    ints_i,
    input  wire plic_cfg_t                   cfg_i,
    input  wire gw_evt_t [`PLIC_TGT_NUM-1:0] claim_i,
    input  wire gw_evt_t [`PLIC_TGT_NUM-1:0] complete_i,
    output src_vec_t                         pend_o
);

    gw_state_e state_q [`PLIC_SRC_NUM];

    for (genvar i = 0; i < `PLIC_SRC_NUM; i++) begin : g_src
        gw_state_e state_d;
        logic      src_act;
        logic      lvl_q;
        logic      lvl_d;
        logic      edge_q;
        logic      pol_q;
        logic      pol_chg;
        logic      is_pend;
        logic      is_cancel;
        logic      claim;
        logic      complete;

        always_comb begin
            claim    = 1'b0;
            complete = 1'b0;
            for (int t = 0; t < `PLIC_TGT_NUM; t++) begin
                claim    |= claim_i[t].valid & (claim_i[t].id == src_id_t'(i));
                complete |= complete_i[t].valid & (complete_i[t].id == src_id_t'(i));
            end
        end

        assign src_act = ints_i[i] ^ cfg_i.src_pol[i];
        assign pol_chg = cfg_i.src_pol[i] ^ pol_q;

        always_ff @(posedge clk or negedge rstn) begin
            if (!rstn) begin
                lvl_q  <= 1'b0;
                lvl_d  <= 1'b0;
                edge_q <= 1'b0;
                pol_q  <= 1'b0;
            end
            else begin
                lvl_q  <= src_act;
                // Old sample re-expressed in the new polarity, no false edge
                lvl_d  <= lvl_q ^ pol_chg;
                edge_q <= lvl_q & ~lvl_d;
                pol_q  <= cfg_i.src_pol[i];
            end
        end

        assign is_pend   = cfg_i.src_type[i] ? lvl_q : edge_q;
        assign is_cancel = (cfg_i.src_type[i] & ~lvl_q) | pol_chg;

        always_comb begin
            state_d = state_q[i];
            case (state_q[i])
                IDLE:    state_d = is_pend ? PEND : IDLE;
                PEND:    state_d = claim ? CLAIM : (is_cancel ? IDLE : PEND);
                CLAIM:   state_d = complete ? IDLE : CLAIM;
                default: state_d = IDLE;
            endcase
        end

        // Reserved source 0 never leaves IDLE
        always_ff @(posedge clk or negedge rstn) begin
            if (!rstn) begin
                state_q[i] <= IDLE;
            end
            else begin
                state_q[i] <= (i == 0) ? IDLE : state_d;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `PLIC_SRC_NUM; i++) begin
            pend_o[i] = (state_q[i] == PEND);
        end
    end

endmodule

`default_nettype wire

// File: rtl/plic_arbiter.sv
`timescale 1ns/100ps
`default_nettype none
`include "plic_defs.svh"

module plic_arbiter import plic_pkg::*; (
    input  wire                                clk,
    input  wire                                rstn,
    input  wire src_vec_t                      pend_i,
    input  wire plic_cfg_t                     cfg_i,
    output tgt_cand_t [`PLIC_TGT_NUM-1:0]      win_o
);

    localparam int N = `PLIC_SRC_NUM;

    for (genvar t = 0; t < `PLIC_TGT_NUM; t++) begin : g_tgt
        src_vec_t  req;
        // Heap order, node k has children 2k and 2k+1, leaves at N..2N-1
        tgt_cand_t node [1:2*N-1];

        assign req = pend_i & cfg_i.enable[t];

        always_comb begin
            for (int i = 0; i < N; i++) begin
                node[N+i].id   = req[i] ? src_id_t'(i) : '0;
                node[N+i].prio = req[i] ? cfg_i.prio[i] : '0;
            end
            // Left child holds the lower ids and keeps ties
            for (int k = N - 1; k >= 1; k--) begin
                if (node[2*k+1].prio > node[2*k].prio) begin
                    node[k] = node[2*k+1];
                end
                else begin
                    node[k] = node[2*k];
                end
            end
        end

        always_ff @(posedge clk or negedge rstn) begin
            if (!rstn) begin
                win_o[t] <= '0;
            end
            else begin
                win_o[t] <= node[1];
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/plic_target.sv
`timescale 1ns/100ps
`default_nettype none
`include "plic_defs.svh"

module plic_target import plic_pkg::*; (
    input  wire                                clk,
    input  wire                                rstn,
    input  wire tgt_cand_t [`PLIC_TGT_NUM-1:0] win_i,
    input  wire plic_cfg_t                     cfg_i,
    input  wire [`PLIC_TGT_NUM-1:0]            claim_rd_i,
    input  wire [`PLIC_TGT_NUM-1:0]            complete_wr_i,
    output src_id_t [`PLIC_TGT_NUM-1:0]        cand_id_o,
    output gw_evt_t [`PLIC_TGT_NUM-1:0]        claim_o,
    output gw_evt_t [`PLIC_TGT_NUM-1:0]        complete_o,
    output logic [`PLIC_TGT_NUM-1:0]           meip_o
);

    for (genvar t = 0; t < `PLIC_TGT_NUM; t++) begin : g_tgt
        src_id_t cand_q;
        src_id_t claimed_q;
        logic    above;

        assign above = win_i[t].prio > cfg_i.threshold[t];

        always_ff @(posedge clk or negedge rstn) begin
            if (!rstn) begin
                cand_q    <= '0;
                claimed_q <= '0;
            end
            else if (complete_wr_i[t]) begin
                cand_q    <= '0;
                claimed_q <= '0;
            end
            else if (claim_rd_i[t] && cand_q != '0) begin
                claimed_q <= cand_q;
            end
            else if (claimed_q == '0) begin
                // Track the winner until something is claimed
                cand_q <= above ? win_i[t].id : '0;
            end
        end

        always_ff @(posedge clk or negedge rstn) begin
            if (!rstn) begin
                meip_o[t] <= 1'b0;
            end
            else begin
                meip_o[t] <= above;
            end
        end

        assign cand_id_o[t] = cand_q;

        assign claim_o[t].valid    = claim_rd_i[t] & (cand_q != '0);
        assign claim_o[t].id       = cand_q;

        // Written value is ignored, the last claimed id is completed
        assign complete_o[t].valid = complete_wr_i[t] & (claimed_q != '0);
        assign complete_o[t].id    = claimed_q;
    end

endmodule

`default_nettype wire

// File: rtl/plic_top.sv
`timescale 1ns/100ps
`default_nettype none
`include "plic_defs.svh"

module plic_top import plic_pkg::*; (
    input  wire                      clk,
    input  wire                      rstn,
    input  wire                      psel_i,
    input  wire                      penable_i,
    input  wire [31:0]               paddr_i,
    input  wire                      pwrite_i,
    input  wire [3:0]                pstrb_i,
    input  wire [31:0]               pwdata_i,
    output logic [31:0]              prdata_o,
    output logic                     pready_o,
    output logic                     pslverr_o,
    input  wire src_vec_t            ints_i,
    output logic [`PLIC_TGT_NUM-1:0] meip_o
);

    apb_req_t                         apb;
    plic_cfg_t                        cfg;
    src_vec_t                         pend;
    tgt_cand_t [`PLIC_TGT_NUM-1:0]    win;
    src_id_t   [`PLIC_TGT_NUM-1:0]    cand_id;
    gw_evt_t   [`PLIC_TGT_NUM-1:0]    claim_evt;
    gw_evt_t   [`PLIC_TGT_NUM-1:0]    complete_evt;
    logic      [`PLIC_TGT_NUM-1:0]    claim_rd;
    logic      [`PLIC_TGT_NUM-1:0]    complete_wr;

    // Whole-word registers only, pstrb_i has no effect
    assign apb.sel    = psel_i;
    assign apb.enable = penable_i;
    assign apb.write  = pwrite_i;
    assign apb.addr   = paddr_i[`PLIC_ADDR_W-1:0];
    assign apb.wdata  = pwdata_i;

    assign pready_o  = 1'b1;
    assign pslverr_o = 1'b0;

    plic_regs u_regs (
        .clk           (clk),
        .rstn          (rstn),
        .apb_i         (apb),
        .pend_i        (pend),
        .cand_id_i     (cand_id),
        .prdata_o      (prdata_o),
        .cfg_o         (cfg),
        .claim_rd_o    (claim_rd),
        .complete_wr_o (complete_wr)
    );

    plic_gateway_bank u_gateway (
        .clk        (clk),
        .rstn       (rstn),
        .ints_i     (ints_i),
        .cfg_i      (cfg),
        .claim_i    (claim_evt),
        .complete_i (complete_evt),
        .pend_o     (pend)
    );

    plic_arbiter u_arbiter (
        .clk    (clk),
        .rstn   (rstn),
        .pend_i (pend),
        .cfg_i  (cfg),
        .win_o  (win)
    );

    plic_target u_target (
        .clk           (clk),
        .rstn          (rstn),
        .win_i         (win),
        .cfg_i         (cfg),
        .claim_rd_i    (claim_rd),
        .complete_wr_i (complete_wr),
        .cand_id_o     (cand_id),
        .claim_o       (claim_evt),
        .complete_o    (complete_evt),
        .meip_o        (meip_o)
    );

endmodule

`default_nettype wire

// File: bench/plic_assert.sv
`timescale 1ns/100ps
`default_nettype none
`include "plic_defs.svh"

module plic_assert import plic_pkg::*; (
    input wire                               clk,
    input wire                               rstn,
    input wire                               pready_i,
    input wire                               pslverr_i,
    input wire [31:0]                        prdata_i,
    input wire [`PLIC_TGT_NUM-1:0]           meip_i,
    input wire src_vec_t [`PLIC_TGT_NUM-1:0] enable_i,
    input wire gw_evt_t [`PLIC_TGT_NUM-1:0]  claim_i
);

    int unsigned err_cnt = 0;
    logic        bad_claim;

    always_comb begin
        bad_claim = 1'b0;
        for (int t = 0; t < `PLIC_TGT_NUM; t++) begin
            bad_claim |= claim_i[t].valid & (claim_i[t].id == '0);
        end
    end

    apb_status_ok: assert property (@(posedge clk) disable iff (!rstn)
        pready_i && !pslverr_i)
    else begin
        err_cnt++;
        $error("pready_o low or pslverr_o high");
    end

    claim_id_ok: assert property (@(posedge clk) disable iff (!rstn) !bad_claim)
    else begin
        err_cnt++;
        $error("claim event with source id zero");
    end

    // Enable reaches meip through the arbiter and target registers
    meip_quiet: assert property (@(posedge clk) disable iff (!rstn)
        (enable_i == '0 && $past(enable_i) == '0 && $past(enable_i, 2) == '0)
        |-> meip_i == '0)
    else begin
        err_cnt++;
        $error("meip_o high with all enables cleared");
    end

    prdata_known: assert property (@(posedge clk) disable iff (!rstn) !$isunknown(prdata_i))
    else begin
        err_cnt++;
        $error("prdata_o has unknown bits");
    end

endmodule

bind plic_top plic_assert u_assert (
    .clk       (clk),
    .rstn      (rstn),
    .pready_i  (pready_o),
    .pslverr_i (pslverr_o),
    .prdata_i  (prdata_o),
    .meip_i    (meip_o),
    .enable_i  (cfg.enable),
    .claim_i   (claim_evt)
);

`default_nettype wire

// File: bench/plic_tb.sv
`timescale 1ns/100ps
`default_nettype none
`include "plic_defs.svh"

module plic_tb import plic_pkg::*; ();

    localparam logic [31:0] pend_addr = 32'(`PLIC_PEND_ADDR);
    localparam logic [31:0] type_addr = 32'(`PLIC_TYPE_ADDR);
    localparam logic [31:0] pol_addr  = 32'(`PLIC_POL_ADDR);

    logic                     clk;
    logic                     rstn;
    logic                     psel;
    logic                     penable;
    logic [31:0]              paddr;
    logic                     pwrite;
    logic [3:0]               pstrb;
    logic [31:0]              pwdata;
    logic [31:0]              prdata;
    logic                     pready;
    logic                     pslverr;
    src_vec_t                 ints;
    logic [`PLIC_TGT_NUM-1:0] meip;

    int seed = 32'h3340_7784;
    int test_errs = 0;
    int errors = 0;
    int tests = 0;
    int failed = 0;

    plic_top u_dut (
        .clk       (clk),
        .rstn      (rstn),
        .psel_i    (psel),
        .penable_i (penable),
        .paddr_i   (paddr),
        .pwrite_i  (pwrite),
        .pstrb_i   (pstrb),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr),
        .ints_i    (ints),
        .meip_o    (meip)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #100us;
        $display("Simulation stopped by the watchdog");
        $display("Result: FAILED");
        $finish;
    end

    function automatic logic [31:0] prio_addr(input int i);
        return 32'(`PLIC_PRIO_BASE) + 32'(4 * i);
    endfunction

    function automatic logic [31:0] en_addr(input int t);
        return 32'(`PLIC_EN_BASE) + 32'(`PLIC_EN_STRIDE) * 32'(t);
    endfunction

    function automatic logic [31:0] th_addr(input int t);
        return 32'(`PLIC_TH_BASE) + 32'(`PLIC_TH_STRIDE) * 32'(t);
    endfunction

    function automatic logic [31:0] claim_addr(input int t);
        return th_addr(t) + 32'h4;
    endfunction

    task automatic note_failure(input string msg);
        $display("%s", msg);
        test_errs++;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
            test_errs++;
        end
    endtask

    task automatic apb_setup(input logic write, input logic [31:0] addr,
                             input logic [31:0] data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= data;
    endtask

    // Access phase, read data is sampled mid-cycle while it is held
    task automatic apb_access(output logic [31:0] data);
        int n;
        @(posedge clk);
        penable <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!pready && n < 20) begin
            @(negedge clk);
            n++;
        end
        assert (pready) else note_failure("pready_o stayed low for 20 cycles");
        data = prdata;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        apb_setup(1'b1, addr, data);
        apb_access(unused);
    endtask

    task automatic read_expect(input logic [31:0] addr, input logic [31:0] exp,
                               input string name);
        logic [31:0] data;
        apb_setup(1'b0, addr, 32'h0);
        apb_access(data);
        check_value(name, data, exp);
    endtask

    task automatic claim_expect(input int t, input logic [31:0] exp);
        read_expect(claim_addr(t), exp, $sformatf("claim[%0d]", t));
    endtask

    task automatic complete(input int t);
        apb_write(claim_addr(t), 32'h0);
    endtask

    task automatic set_ints(input src_vec_t v);
        @(posedge clk);
        ints <= v;
    endtask

    task automatic wait_meip(input int t, input logic level);
        int  n;
        logic seen;
        seen = 1'b0;
        for (n = 0; n < 20 && !seen; n++) begin
            @(negedge clk);
            seen = (meip[t] == level);
        end
        assert (seen) else note_failure($sformatf("meip_o[%0d] did not %s within 20 cycles",
                                                  t, level ? "rise" : "fall"));
    endtask

    task automatic expect_meip_low(input int t, input int cycles);
        int n;
        for (n = 0; n < cycles; n++) begin
            @(negedge clk);
            check_value($sformatf("meip_o[%0d]", t), 32'(meip[t]), 32'h0);
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        errors += test_errs;
        if (test_errs != 0) begin
            failed++;
        end
        $display("Test %0d %s: %0d errors", tests, name, test_errs);
        test_errs = 0;
    endtask

    initial begin
        logic [31:0] exp_prio [`PLIC_SRC_NUM];
        logic [31:0] d;
        int          pa;
        int          pb;
        int          win_id;

        rstn    = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        paddr   = '0;
        pwrite  = 1'b0;
        pstrb   = 4'hf;
        pwdata  = '0;
        ints    = '0;
        repeat (2) @(posedge clk);
        rstn <= 1'b1;

        // Register access
        for (int i = 0; i < `PLIC_SRC_NUM; i++) begin
            read_expect(prio_addr(i), 32'h0, $sformatf("prio[%0d]", i));
        end
        read_expect(pend_addr, 32'h0, "pending");
        read_expect(type_addr, 32'h0, "type");
        read_expect(pol_addr, 32'h0, "polarity");
        for (int t = 0; t < `PLIC_TGT_NUM; t++) begin
            read_expect(en_addr(t), 32'h0, $sformatf("enable[%0d]", t));
            read_expect(th_addr(t), 32'h0, $sformatf("threshold[%0d]", t));
            claim_expect(t, 32'h0);
        end
        for (int i = 0; i < `PLIC_SRC_NUM; i++) begin
            d = $random(seed);
            exp_prio[i] = (i == 0) ? 32'h0 : d & ((32'h1 << `PLIC_PRIO_W) - 32'h1);
            apb_write(prio_addr(i), d);
        end
        for (int i = 0; i < `PLIC_SRC_NUM; i++) begin
            read_expect(prio_addr(i), exp_prio[i], $sformatf("prio[%0d]", i));
        end
        apb_write(en_addr(0), 32'hffff_a5a5);
        apb_write(en_addr(1), 32'h0000_5a5a);
        apb_write(type_addr, 32'h0000_1234);
        apb_write(pol_addr, 32'h0000_c000);
        apb_write(th_addr(0), 32'hffff_fff5);
        apb_write(th_addr(1), 32'h0000_0002);
        read_expect(en_addr(0), 32'h0000_a5a5, "enable[0]");
        read_expect(en_addr(1), 32'h0000_5a5a, "enable[1]");
        read_expect(type_addr, 32'h0000_1234, "type");
        read_expect(pol_addr, 32'h0000_c000, "polarity");
        read_expect(th_addr(0), 32'h5, "threshold[0]");
        read_expect(th_addr(1), 32'h2, "threshold[1]");
        apb_write(pend_addr, 32'h0000_ffff);
        read_expect(pend_addr, 32'h0, "pending");
        apb_write(en_addr(0), 32'h0);
        apb_write(en_addr(1), 32'h0);
        apb_write(pol_addr, 32'h0);
        apb_write(type_addr, 32'h0);
        end_test("register access");

        // Level source 5 on target 0 only
        apb_write(type_addr, 32'h0000_0020);
        apb_write(prio_addr(5), 32'h6);
        apb_write(th_addr(0), 32'h2);
        apb_write(th_addr(1), 32'h0);
        // Pending while no target has it enabled yet
        set_ints(16'h0020);
        expect_meip_low(0, 8);
        apb_write(en_addr(0), 32'h0000_0020);
        wait_meip(0, 1'b1);
        check_value("meip_o[1]", 32'(meip[1]), 32'h0);
        read_expect(pend_addr, 32'h0000_0020, "pending");
        claim_expect(0, 32'd5);
        read_expect(pend_addr, 32'h0, "pending");
        check_value("meip_o[1]", 32'(meip[1]), 32'h0);
        set_ints(16'h0000);
        complete(0);
        wait_meip(0, 1'b0);
        end_test("level delivery");

        // Sources 3 and 9 competing on target 0
        apb_write(type_addr, 32'h0000_0208);
        apb_write(th_addr(0), 32'h0);
        apb_write(en_addr(0), 32'h0000_0208);
        pa = 1 + int'($unsigned($random(seed)) % 32'd7);
        pb = 1 + int'((32'(pa) + $unsigned($random(seed)) % 32'd6) % 32'd7);
        win_id = (pa > pb) ? 3 : 9;
        apb_write(prio_addr(3), 32'(pa));
        apb_write(prio_addr(9), 32'(pb));
        set_ints(16'h0208);
        wait_meip(0, 1'b1);
        claim_expect(0, 32'(win_id));
        set_ints(16'h0000);
        complete(0);
        wait_meip(0, 1'b0);
        apb_write(prio_addr(3), 32'h4);
        apb_write(prio_addr(9), 32'h4);
        set_ints(16'h0208);
        wait_meip(0, 1'b1);
        claim_expect(0, 32'd3);
        set_ints(16'h0000);
        complete(0);
        wait_meip(0, 1'b0);
        claim_expect(0, 32'h0);
        end_test("arbitration");

        // Source 7 at and below the threshold, then above it
        apb_write(type_addr, 32'h0000_0080);
        apb_write(prio_addr(7), 32'h3);
        apb_write(th_addr(0), 32'h3);
        apb_write(en_addr(0), 32'h0000_0080);
        set_ints(16'h0080);
        expect_meip_low(0, 20);
        apb_write(prio_addr(7), 32'h2);
        expect_meip_low(0, 20);
        apb_write(prio_addr(7), 32'h4);
        wait_meip(0, 1'b1);
        set_ints(16'h0000);
        wait_meip(0, 1'b0);
        end_test("threshold");

        // Active-low edge source 11, input idles high
        apb_write(type_addr, 32'h0);
        apb_write(pol_addr, 32'h0000_0800);
        set_ints(16'h0800);
        apb_write(prio_addr(11), 32'h5);
        apb_write(th_addr(0), 32'h0);
        apb_write(en_addr(0), 32'h0000_0800);
        read_expect(pend_addr, 32'h0, "pending");
        for (int p = 0; p < 2; p++) begin
            set_ints(16'h0000);
            wait_meip(0, 1'b1);
            read_expect(pend_addr, 32'h0000_0800, "pending");
            claim_expect(0, 32'd11);
            complete(0);
            expect_meip_low(0, 8);
            read_expect(pend_addr, 32'h0, "pending");
            set_ints(16'h0800);
        end
        apb_write(en_addr(0), 32'h0);
        apb_write(pol_addr, 32'h0);
        set_ints(16'h0000);
        // Level source 5 held active through its completion
        apb_write(type_addr, 32'h0000_0020);
        apb_write(prio_addr(5), 32'h6);
        apb_write(en_addr(0), 32'h0000_0020);
        set_ints(16'h0020);
        wait_meip(0, 1'b1);
        claim_expect(0, 32'd5);
        read_expect(pend_addr, 32'h0, "pending");
        complete(0);
        wait_meip(0, 1'b1);
        read_expect(pend_addr, 32'h0000_0020, "pending");
        claim_expect(0, 32'd5);
        set_ints(16'h0000);
        complete(0);
        wait_meip(0, 1'b0);
        end_test("edge and polarity");

        // Source 9 shared by both targets
        apb_write(type_addr, 32'h0000_0200);
        apb_write(prio_addr(9), 32'h5);
        apb_write(th_addr(1), 32'h0);
        apb_write(en_addr(0), 32'h0000_0200);
        apb_write(en_addr(1), 32'h0000_0200);
        set_ints(16'h0200);
        wait_meip(0, 1'b1);
        wait_meip(1, 1'b1);
        claim_expect(0, 32'd9);
        claim_expect(1, 32'h0);
        complete(0);
        wait_meip(1, 1'b1);
        claim_expect(1, 32'd9);
        set_ints(16'h0000);
        complete(1);
        wait_meip(1, 1'b0);
        wait_meip(0, 1'b0);
        apb_write(en_addr(0), 32'h0);
        apb_write(en_addr(1), 32'h0);
        end_test("shared source");

        repeat (4) @(posedge clk);
        $display("Tests: %0d, failed: %0d, check errors: %0d, assertion errors: %0d",
                 tests, failed, errors, u_dut.u_assert.err_cnt);
        if (errors == 0 && u_dut.u_assert.err_cnt == 0) begin
            $display("Result: PASSED");
        end
        else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+rtl
rtl/plic_pkg.sv
rtl/plic_regs.sv
rtl/plic_gateway_bank.sv
rtl/plic_arbiter.sv
rtl/plic_target.sv
rtl/plic_top.sv
bench/plic_assert.sv
bench/plic_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the PLIC testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module plic_tb \
    -f project.f -o plic_sim

./obj_dir/plic_sim +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
grep -q "Result: PASSED" sim.log
